// File: design/fp_alu_consts.svh
`ifndef FP_ALU_CONSTS_SVH
`define FP_ALU_CONSTS_SVH

// ==============================
// Field and datapath sizes
// ==============================
`define FP_FIELD_WIDTH 512
`define FP_WORD_WIDTH  32
`define FP_WORDS       16   // Slices per field element
`define FP_OP_WIDTH    2

// CSIDH-512 prime
`define FP_PRIME {128'h65b48e8f740f89bffc8ab0d15e3e4c4a, \
                  128'hb42d083aedc88c425afbfcc69322c9cd, \
                  128'ha7aac6c567f35507516730cc1f0b4f25, \
                  128'hc2721bf457aca8351b81b90533c6c87b}

`endif

// File: design/fp_alu_pkg.sv
`default_nettype none

package fp_alu_pkg;

`include "fp_alu_consts.svh"

    typedef logic [`FP_FIELD_WIDTH-1:0]   field_t;
    typedef logic [`FP_FIELD_WIDTH:0]     field_ext_t;   // Field element plus carry
    typedef logic [`FP_WORD_WIDTH-1:0]    word_t;
    typedef logic [2*`FP_FIELD_WIDTH-1:0] product_t;

    typedef enum logic [`FP_OP_WIDTH-1:0] {
        OP_RESERVED = 2'b00,
        OP_ADD      = 2'b01,
        OP_SUB      = 2'b10,
        OP_MUL      = 2'b11
    } op_t;

    typedef struct packed {
        op_t    op;
        field_t a;
        field_t b;
    } alu_req_t;

    typedef struct packed {
        field_ext_t x;
        field_ext_t y;
        logic       subtract;   // x - y when set
    } add_req_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_PASS1,
        SEQ_PASS2,
        SEQ_MUL
    } seq_state_t;

endpackage

`default_nettype wire

// File: design/fp_operand_latch.sv
`timescale 1ns/1ps
`default_nettype none

module fp_operand_latch (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      start,
    input  wire fp_alu_pkg::op_t     op,
    input  wire fp_alu_pkg::field_t  a,
    input  wire fp_alu_pkg::field_t  b,
    input  wire                      seq_done,
    output fp_alu_pkg::alu_req_t     req,
    output logic                     req_valid,
    output logic                     busy
);

    logic accept;

    assign accept = start && !busy;   // Starts during an operation are dropped

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
            busy      <= 1'b0;
        end else begin
            req_valid <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (seq_done) begin
                busy <= 1'b0;
            end
        end
    end

    // Request stays stable until the next accepted start
    always_ff @(posedge clk) begin
        if (accept) begin
            req.op <= op;
            req.a  <= a;
            req.b  <= b;
        end
    end

endmodule

`default_nettype wire

// File: design/fp_carry_select_adder.sv
`timescale 1ns/1ps
`default_nettype none
`include "fp_alu_consts.svh"

module fp_carry_select_adder (
    input  wire                        clk,
    input  wire                        rst,
    input  wire fp_alu_pkg::add_req_t  add_req,
    input  wire                        add_go,
    output fp_alu_pkg::field_ext_t     sum,
    output logic                       carry_out,
    output logic                       add_done
);

    localparam int W      = `FP_WORD_WIDTH;
    localparam int SLICES = `FP_WORDS + 1;   // Top slice carries bit 512 and the carry
    localparam int PAD_W  = SLICES * W;

    fp_alu_pkg::field_ext_t y_in;
    logic [PAD_W-1:0]       x_pad;
    logic [PAD_W-1:0]       y_pad;
    logic [W:0]             part0 [SLICES];
    logic [W:0]             part1 [SLICES];
    logic                   carry_in;
    logic [PAD_W-1:0]       joined;

    assign y_in  = add_req.subtract ? ~add_req.y : add_req.y;
    assign x_pad = PAD_W'(add_req.x);
    assign y_pad = PAD_W'(y_in);

    always_ff @(posedge clk) begin
        if (rst) begin
            add_done <= 1'b0;
        end else begin
            add_done <= add_go;
        end
    end

    // ==============================
    // Cycle 1: both candidate sums per slice
    // ==============================
    always_ff @(posedge clk) begin
        if (add_go) begin
            carry_in <= add_req.subtract;   // Completes the two's complement of y
            for (int i = 0; i < SLICES; i++) begin
                part0[i] <= {1'b0, x_pad[i*W +: W]} + {1'b0, y_pad[i*W +: W]};
                part1[i] <= {1'b0, x_pad[i*W +: W]} + {1'b0, y_pad[i*W +: W]} + 1'b1;
            end
        end
    end

    // ==============================
    // Cycle 2: carry ripple picks a sum
    // ==============================
    always_comb begin
        logic c;
        c = carry_in;
        for (int i = 0; i < SLICES; i++) begin
            if (c) begin
                joined[i*W +: W] = part1[i][W-1:0];
                c = part1[i][W];
            end else begin
                joined[i*W +: W] = part0[i][W-1:0];
                c = part0[i][W];
            end
        end
    end

    assign sum       = joined[`FP_FIELD_WIDTH:0];
    assign carry_out = joined[`FP_FIELD_WIDTH+1];   // High means no borrow on subtract

endmodule

`default_nettype wire

// File: design/fp_word_multiplier.sv
`timescale 1ns/1ps
`default_nettype none
`include "fp_alu_consts.svh"

module fp_word_multiplier (
    input  wire                      clk,
    input  wire                      rst,
    input  wire fp_alu_pkg::field_t  x,
    input  wire fp_alu_pkg::field_t  y,
    input  wire                      mul_go,
    output fp_alu_pkg::product_t     product,
    output logic                     mul_done
);

    localparam int W     = `FP_WORD_WIDTH;
    localparam int ROW_W = (`FP_WORDS + 1) * W;   // One row of x times a word
    localparam int CNT_W = $clog2(`FP_WORDS);

    fp_alu_pkg::field_t   x_q;
    fp_alu_pkg::field_t   y_q;      // Next word of y sits at the bottom
    fp_alu_pkg::word_t    y_word;
    fp_alu_pkg::product_t acc;
    logic [CNT_W-1:0]     cnt;
    logic                 running;
    logic [2*W-1:0]       pp [`FP_WORDS];
    logic [ROW_W-1:0]     lo_vec;
    logic [ROW_W-1:0]     hi_vec;
    logic [ROW_W-1:0]     row;
    logic [ROW_W-1:0]     window_sum;

    // Word-sliced carry-select add over one row width
    function automatic logic [ROW_W-1:0] cs_add(input logic [ROW_W-1:0] p,
                                                input logic [ROW_W-1:0] q);
        logic [W:0]       s0;
        logic [W:0]       s1;
        logic             c;
        logic [ROW_W-1:0] r;
        c = 1'b0;
        for (int i = 0; i <= `FP_WORDS; i++) begin
            s0 = {1'b0, p[i*W +: W]} + {1'b0, q[i*W +: W]};
            s1 = s0 + 1'b1;
            r[i*W +: W] = c ? s1[W-1:0] : s0[W-1:0];
            c = c ? s1[W] : s0[W];
        end
        return r;
    endfunction

    assign y_word = y_q[W-1:0];

    // ==============================
    // Partial products of x and one word
    // ==============================
    always_comb begin
        lo_vec = '0;
        hi_vec = '0;
        for (int i = 0; i < `FP_WORDS; i++) begin
            pp[i] = x_q[i*W +: W] * y_word;
            lo_vec[i*W +: W]     = pp[i][W-1:0];
            hi_vec[(i+1)*W +: W] = pp[i][2*W-1:W];   // High halves land one word up
        end
    end

    assign row        = cs_add(lo_vec, hi_vec);
    assign window_sum = cs_add(acc[cnt*W +: ROW_W], row);
    assign product    = acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            running  <= 1'b0;
            cnt      <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            if (mul_go) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(`FP_WORDS - 1)) begin   // Last row goes in now
                    running  <= 1'b0;
                    mul_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_go) begin
            x_q <= x;
            y_q <= y;
            acc <= '0;
        end else if (running) begin
            acc[cnt*W +: ROW_W] <= window_sum;
            y_q <= y_q >> W;
        end
    end

endmodule

`default_nettype wire

// File: design/fp_mod_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "fp_alu_consts.svh"

module fp_mod_sequencer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire fp_alu_pkg::alu_req_t    req,
    input  wire                          req_valid,
    output fp_alu_pkg::add_req_t         add_req,
    output logic                         add_go,
    input  wire fp_alu_pkg::field_ext_t  sum,
    input  wire                          carry_out,
    input  wire                          add_done,
    output logic                         mul_go,
    input  wire fp_alu_pkg::product_t    product,
    input  wire                          mul_done,
    output fp_alu_pkg::product_t         seq_result,
    output logic                         seq_done
);

    localparam fp_alu_pkg::field_ext_t P_EXT = {1'b0, `FP_PRIME};

    fp_alu_pkg::seq_state_t state;
    fp_alu_pkg::field_ext_t first_sum;   // a + b, kept while testing against p

    function automatic fp_alu_pkg::product_t widen(input fp_alu_pkg::field_t f);
        return {{`FP_FIELD_WIDTH{1'b0}}, f};
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= fp_alu_pkg::SEQ_IDLE;
            add_go   <= 1'b0;
            mul_go   <= 1'b0;
            seq_done <= 1'b0;
        end else begin
            add_go   <= 1'b0;
            mul_go   <= 1'b0;
            seq_done <= 1'b0;
            case (state)
                fp_alu_pkg::SEQ_IDLE: begin
                    if (req_valid) begin
                        case (req.op)
                            fp_alu_pkg::OP_ADD, fp_alu_pkg::OP_SUB: begin
                                add_req <= '{{1'b0, req.a}, {1'b0, req.b},
                                             req.op == fp_alu_pkg::OP_SUB};
                                add_go  <= 1'b1;
                                state   <= fp_alu_pkg::SEQ_PASS1;
                            end
                            fp_alu_pkg::OP_MUL: begin
                                mul_go <= 1'b1;   // Operands go straight from req
                                state  <= fp_alu_pkg::SEQ_MUL;
                            end
                            default: begin
                                seq_result <= '0;
                                seq_done   <= 1'b1;
                            end
                        endcase
                    end
                end
                // ==============================
                // First adder result
                // ==============================
                fp_alu_pkg::SEQ_PASS1: begin
                    if (add_done) begin
                        if (req.op == fp_alu_pkg::OP_ADD) begin
                            first_sum <= sum;
                            add_req   <= '{sum, P_EXT, 1'b1};   // Try s - p
                            add_go    <= 1'b1;
                            state     <= fp_alu_pkg::SEQ_PASS2;
                        end else if (carry_out) begin
                            seq_result <= widen(sum[`FP_FIELD_WIDTH-1:0]);
                            seq_done   <= 1'b1;
                            state      <= fp_alu_pkg::SEQ_IDLE;
                        end else begin
                            add_req <= '{sum, P_EXT, 1'b0};   // Borrow, wrap by p
                            add_go  <= 1'b1;
                            state   <= fp_alu_pkg::SEQ_PASS2;
                        end
                    end
                end
                fp_alu_pkg::SEQ_PASS2: begin
                    if (add_done) begin
                        if (req.op == fp_alu_pkg::OP_ADD && !carry_out) begin
                            seq_result <= widen(first_sum[`FP_FIELD_WIDTH-1:0]);
                        end else begin
                            seq_result <= widen(sum[`FP_FIELD_WIDTH-1:0]);
                        end
                        seq_done <= 1'b1;
                        state    <= fp_alu_pkg::SEQ_IDLE;
                    end
                end
                fp_alu_pkg::SEQ_MUL: begin
                    if (mul_done) begin
                        seq_result <= product;
                        seq_done   <= 1'b1;
                        state      <= fp_alu_pkg::SEQ_IDLE;
                    end
                end
                default: state <= fp_alu_pkg::SEQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/fp_result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fp_result_stage (
    input  wire                        clk,
    input  wire                        rst,
    input  wire fp_alu_pkg::product_t  seq_result,
    input  wire                        seq_done,
    input  wire                        req_valid,
    output fp_alu_pkg::product_t       result,
    output logic                       done
);

    logic done_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
            done_q <= 1'b0;
        end else if (seq_done) begin
            result <= seq_result;
            done_q <= 1'b1;
        end else if (req_valid) begin
            done_q <= 1'b0;   // New request accepted
        end
    end

    // Drops in the same cycle that busy rises
    assign done = done_q && !req_valid;

endmodule

`default_nettype wire

// File: design/fp_alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module fp_alu_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      start,
    input  wire fp_alu_pkg::op_t     op,
    input  wire fp_alu_pkg::field_t  a,
    input  wire fp_alu_pkg::field_t  b,
    output fp_alu_pkg::product_t     result,
    output logic                     done,
    output logic                     busy
);

    fp_alu_pkg::alu_req_t   req;
    logic                   req_valid;
    logic                   seq_done;
    fp_alu_pkg::add_req_t   add_req;
    logic                   add_go;
    fp_alu_pkg::field_ext_t sum;
    logic                   carry_out;
    logic                   add_done;
    logic                   mul_go;
    fp_alu_pkg::product_t   product;
    logic                   mul_done;
    fp_alu_pkg::product_t   seq_result;

    fp_operand_latch u_latch (
        .clk(clk), .rst(rst), .start(start), .op(op), .a(a), .b(b),
        .seq_done(seq_done), .req(req), .req_valid(req_valid), .busy(busy)
    );

    fp_mod_sequencer u_seq (
        .clk(clk), .rst(rst), .req(req), .req_valid(req_valid),
        .add_req(add_req), .add_go(add_go), .sum(sum), .carry_out(carry_out),
        .add_done(add_done), .mul_go(mul_go), .product(product), .mul_done(mul_done),
        .seq_result(seq_result), .seq_done(seq_done)
    );

    fp_carry_select_adder u_adder (
        .clk(clk), .rst(rst), .add_req(add_req), .add_go(add_go),
        .sum(sum), .carry_out(carry_out), .add_done(add_done)
    );

    // Multiplier takes its operands straight from the held request
    fp_word_multiplier u_mul (
        .clk(clk), .rst(rst), .x(req.a), .y(req.b), .mul_go(mul_go),
        .product(product), .mul_done(mul_done)
    );

    fp_result_stage u_result (
        .clk(clk), .rst(rst), .seq_result(seq_result), .seq_done(seq_done),
        .req_valid(req_valid), .result(result), .done(done)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/fp_alu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fp_alu_checker (
    input wire                          clk,
    input wire                          rst,
    input wire                          start,
    input wire                          busy,
    input wire                          done,
    input wire fp_alu_pkg::seq_state_t  seq_state
);

    // ==============================
    // Control protocol
    // ==============================
    assert property (@(posedge clk) disable iff (rst) $rose(done) |-> $past(busy))
        else $error("done rose without busy in the previous cycle");

    assert property (@(posedge clk) disable iff (rst) $fell(done) |-> $past(start && !busy))
        else $error("done fell without an accepted start");

    assert property (@(posedge clk) disable iff (rst) !(busy && done))
        else $error("busy and done high together");

    assert property (@(posedge clk) disable iff (rst)
                     $rose(done) |-> seq_state == fp_alu_pkg::SEQ_IDLE)
        else $error("done rose while the sequencer was still working");

    // Reset clears the done level
    assert property (@(posedge clk) rst |=> !done)
        else $error("done high in the cycle after reset");

endmodule

bind fp_alu_top fp_alu_checker u_checker (
    .clk(clk), .rst(rst), .start(start), .busy(busy), .done(done),
    .seq_state(u_seq.state)
);

`default_nettype wire

// File: tests/fp_alu_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "fp_alu_consts.svh"

module fp_alu_tb;

    localparam int W     = `FP_WORD_WIDTH;
    localparam int FW    = `FP_FIELD_WIDTH;
    localparam int N_OPS = 112;   // Every start issued below, with some spare
    localparam fp_alu_pkg::field_t P = `FP_PRIME;

    logic                 clk;
    logic                 rst;
    logic                 start;
    fp_alu_pkg::op_t      op_in;
    fp_alu_pkg::field_t   a_in;
    fp_alu_pkg::field_t   b_in;
    fp_alu_pkg::product_t result;
    logic                 done;
    logic                 busy;

    integer               seed = 76007;
    int                   n_sent = 0;
    int                   n_checked = 0;
    fp_alu_pkg::product_t exp_q[$];
    fp_alu_pkg::op_t      kind_q[$];

    tb_clock_gen u_clk (.clk(clk), .rst(rst));

    fp_alu_top DUT (
        .clk(clk), .rst(rst), .start(start), .op(op_in), .a(a_in), .b(b_in),
        .result(result), .done(done), .busy(busy)
    );

    // ==============================
    // Reference model and checks
    // ==============================
    function automatic fp_alu_pkg::product_t ref_result(input fp_alu_pkg::op_t o,
                                                        input fp_alu_pkg::field_t x,
                                                        input fp_alu_pkg::field_t y);
        logic [FW:0]          s;
        fp_alu_pkg::product_t xw;
        fp_alu_pkg::product_t yw;
        fp_alu_pkg::product_t r;
        r  = '0;
        xw = '0;
        yw = '0;
        xw[FW-1:0] = x;
        yw[FW-1:0] = y;
        case (o)
            fp_alu_pkg::OP_ADD: begin
                s = {1'b0, x} + {1'b0, y};
                if (s >= {1'b0, P}) s = s - {1'b0, P};
                r[FW-1:0] = s[FW-1:0];
            end
            fp_alu_pkg::OP_SUB: begin
                if (x >= y) s = {1'b0, x} - {1'b0, y};
                else s = {1'b0, x} + {1'b0, P} - {1'b0, y};   // Wrap by p
                r[FW-1:0] = s[FW-1:0];
            end
            fp_alu_pkg::OP_MUL: r = xw * yw;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic fp_alu_pkg::field_t rand_field();
        fp_alu_pkg::field_t v;
        for (int i = 0; i < `FP_WORDS; i++) begin
            v[i*W +: W] = $random(seed);
        end
        v[FW-1] = 1'b0;
        if (v >= P) v = v - P;   // Below 2^511, so once is enough
        return v;
    endfunction

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_field(input fp_alu_pkg::field_t got, input fp_alu_pkg::field_t expected,
                               input fp_alu_pkg::field_t upper, input string what);
        if (upper !== '0) begin
            stop_with_error($sformatf("FAILED at %0t: %s upper half not zero, got %h",
                                      $time, what, upper));
        end else if (got !== expected) begin
            stop_with_error($sformatf("FAILED at %0t: %s got %h expected %h",
                                      $time, what, got, expected));
        end
    endtask

    task automatic check_product(input fp_alu_pkg::product_t got,
                                 input fp_alu_pkg::product_t expected, input string what);
        if (got !== expected) begin
            stop_with_error($sformatf("FAILED at %0t: %s got %h expected %h",
                                      $time, what, got, expected));
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            stop_with_error($sformatf("FAILED at %0t: %s got %b expected %b",
                                      $time, what, got, expected));
        end
    endtask

    // ==============================
    // Stimulus helpers
    // ==============================
    task automatic send_op(input fp_alu_pkg::op_t o, input fp_alu_pkg::field_t x,
                           input fp_alu_pkg::field_t y, input logic expect_done);
        @(posedge clk);
        start <= 1'b1;
        op_in <= o;
        a_in  <= x;
        b_in  <= y;
        if (expect_done) begin
            exp_q.push_back(ref_result(o, x, y));
            kind_q.push_back(o);
            n_sent++;
        end
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_all_done();
        while (n_checked != n_sent) @(posedge clk);
    endtask

    task automatic run_op(input fp_alu_pkg::op_t o, input fp_alu_pkg::field_t x,
                          input fp_alu_pkg::field_t y);
        send_op(o, x, y, 1'b1);
        wait_all_done();
    endtask

    // Compares each completion against the oldest expected value
    initial begin : compare
        fp_alu_pkg::product_t expected;
        fp_alu_pkg::op_t      kind;
        logic                 done_prev;
        done_prev = 1'b0;
        @(negedge rst);
        forever begin
            @(posedge clk);
            if (done && !done_prev) begin
                if (exp_q.size() == 0) begin
                    stop_with_error("done rose although no request was outstanding");
                end else begin
                    expected = exp_q.pop_front();
                    kind     = kind_q.pop_front();
                    if (kind == fp_alu_pkg::OP_ADD || kind == fp_alu_pkg::OP_SUB) begin
                        check_field(result[FW-1:0], expected[FW-1:0], result[2*FW-1:FW],
                                    $sformatf("%s op %0d", kind.name(), n_checked));
                    end else begin
                        check_product(result, expected,
                                      $sformatf("%s op %0d", kind.name(), n_checked));
                    end
                    n_checked++;
                end
            end
            done_prev = done;
        end
    end

    initial begin : watchdog
        repeat (8 + N_OPS * (`FP_WORDS + 10)) @(posedge clk);
        stop_with_error("Timeout: done never arrived within the cycle budget");
    end

    initial begin : stimulus
        fp_alu_pkg::field_t   x;
        fp_alu_pkg::field_t   y;
        fp_alu_pkg::product_t held;
        start = 1'b0;
        op_in = fp_alu_pkg::OP_RESERVED;
        a_in  = '0;
        b_in  = '0;
        @(negedge rst);

        run_op(fp_alu_pkg::OP_ADD, '0, '0);
        run_op(fp_alu_pkg::OP_ADD, P - 1, 1);
        run_op(fp_alu_pkg::OP_ADD, P - 1, P - 1);
        repeat (40) begin
            x = rand_field();
            y = rand_field();
            run_op(fp_alu_pkg::OP_ADD, x, y);
        end

        x = rand_field();
        run_op(fp_alu_pkg::OP_SUB, x, x);
        run_op(fp_alu_pkg::OP_SUB, '0, 1);
        repeat (40) begin
            x = rand_field();
            y = rand_field();
            run_op(fp_alu_pkg::OP_SUB, x, y);
        end

        run_op(fp_alu_pkg::OP_MUL, '1, '1);   // (2^512-1)^2
        run_op(fp_alu_pkg::OP_MUL, '0, rand_field());
        repeat (20) begin
            x = rand_field();
            y = rand_field();
            run_op(fp_alu_pkg::OP_MUL, x, y);
        end

        // Second start lands while the multiply is running
        x = rand_field();
        y = rand_field();
        send_op(fp_alu_pkg::OP_MUL, x, y, 1'b1);
        repeat (2) @(posedge clk);
        check_flag(busy, 1'b1, "busy during multiply");
        send_op(fp_alu_pkg::OP_ADD, y, x, 1'b0);
        wait_all_done();

        held = ref_result(fp_alu_pkg::OP_MUL, x, y);   // First request's product
        repeat (5) begin
            @(posedge clk);
            check_flag(done, 1'b1, "done while idle");
            check_product(result, held, "result while idle");
        end

        send_op(fp_alu_pkg::OP_RESERVED, x, y, 1'b1);
        @(posedge clk);
        check_flag(done, 1'b0, "done after next start");
        wait_all_done();
        check_flag(done, 1'b1, "done after reserved op");

        repeat (3) @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: fp_alu.f
+incdir+design
design/fp_alu_pkg.sv
design/fp_operand_latch.sv
design/fp_carry_select_adder.sv
design/fp_word_multiplier.sv
design/fp_mod_sequencer.sv
design/fp_result_stage.sv
design/fp_alu_top.sv
tests/tb_clock_gen.sv
tests/fp_alu_checker.sv
tests/fp_alu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f fp_alu.f \
    --top-module fp_alu_tb -o fp_alu_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/fp_alu_sim > "$LOG" 2>&1
cat "$LOG"

grep -Fqx 'All tests passed!' "$LOG" && echo "Simulation PASSED" \
    || { echo "Simulation FAILED, see $LOG"; exit 1; }
